// ==== bench/mcu_assertions.sv ====
// MCU protocol checker: bus handshake rules and SPI select rules, bound to the top level
`timescale 1ns/1ps

module mcu_assertions (
  input logic                  clk,
  input logic                  rst_n,
  input mcu_pkg::mas_send_type inst_req,
  input mcu_pkg::slv_send_type inst_rsp,
  input mcu_pkg::mas_send_type data_req,
  input mcu_pkg::slv_send_type data_rsp,
  input logic                  sclk,
  input logic                  ss_0,
  input logic                  ss_1,
  input logic                  ss_2,
  input logic                  ss_3
);

  // Failure count, read by the testbench summary
  int fail_cnt = 0;

  // --------------------
  // SPI pins
  // --------------------

  // At most one slave selected
  ss_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(~{ss_3, ss_2, ss_1, ss_0}))
  else begin
    fail_cnt++;
    $error("more than one ss line low");
  end

  // No clock without a selected slave
  sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (&{ss_3, ss_2, ss_1, ss_0}) |-> !sclk)
  else begin
    fail_cnt++;
    $error("sclk high while all ss lines high");
  end

  // --------------------
  // System bus
  // --------------------

  inst_err_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    inst_rsp.hresp |-> inst_rsp.hready)
  else begin
    fail_cnt++;
    $error("inst_rsp.hresp without hready");
  end

  data_err_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    data_rsp.hresp |-> data_rsp.hready)
  else begin
    fail_cnt++;
    $error("data_rsp.hresp without hready");
  end

  // Pending request held until its hready
  inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (inst_req.hreq && !inst_rsp.hready) |=> $stable(inst_req))
  else begin
    fail_cnt++;
    $error("inst_req changed before hready");
  end

  data_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req.hreq && !data_rsp.hready) |=> $stable(data_req))
  else begin
    fail_cnt++;
    $error("data_req changed before hready");
  end

endmodule

bind mcu_top mcu_assertions u_chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .inst_req (inst_req),
  .inst_rsp (inst_rsp),
  .data_req (data_req),
  .data_rsp (data_rsp),
  .sclk     (sclk),
  .ss_0     (ss_0),
  .ss_1     (ss_1),
  .ss_2     (ss_2),
  .ss_3     (ss_3)
);

// ==== bench/mcu_tb.sv ====
// MCU testbench: drives both master ports through memory, arbitration, decode and SPI tests
`timescale 1ns/1ps

module mcu_tb;

  localparam int mem_depth   = 1024;
  localparam int spi_clk_div = 4;
  localparam int n_tests     = 5;
  localparam int n_words     = 8;
  // Cycle budget per test, one SPI byte included
  localparam int test_cycles = 200 + 32 * spi_clk_div;

  logic                  clk;
  logic                  rst_n;
  mcu_pkg::mas_send_type inst_req;
  mcu_pkg::slv_send_type inst_rsp;
  mcu_pkg::mas_send_type data_req;
  mcu_pkg::slv_send_type data_rsp;
  logic                  mosi_somi;
  logic                  sclk;
  logic                  ss_0;
  logic                  ss_1;
  logic                  ss_2;
  logic                  ss_3;
  logic                  miso_simo;

  integer      seed;
  int          errors;
  int          tests_run;
  int          test_err0;
  logic [3:0]  ss_snap;  // ss lines at the last hready
  logic [3:0]  ss_prev;
  logic        polled_busy;
  logic        ss_checked;
  logic [31:0] addr_list [n_words];
  logic [31:0] word_list [n_words];
  logic [31:0] rdata;
  logic [31:0] rd_i;
  logic [31:0] rd_d;
  logic        err;
  logic        err_i;
  logic        err_d;
  logic [7:0]  tx_byte;

  // SPI loopback
  assign miso_simo = mosi_somi;

  mcu_top #(
    .mem_depth   (mem_depth),
    .spi_clk_div (spi_clk_div)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst_req  (inst_req),
    .inst_rsp  (inst_rsp),
    .data_req  (data_req),
    .data_rsp  (data_rsp),
    .mosi_somi (mosi_somi),
    .sclk      (sclk),
    .ss_0      (ss_0),
    .ss_1      (ss_1),
    .ss_2      (ss_2),
    .ss_3      (ss_3),
    .miso_simo (miso_simo)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  initial begin
    repeat (8 + n_tests * test_cycles) @(posedge clk);
    $display("Error: watchdog expired, a bus transfer or SPI byte never completed");
    $display("Finished with errors");
    $finish;
  end

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] peri_addr(input logic [7:0] off);
    return {mcu_pkg::peri_region, 20'h0, off};
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("** Error: %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  // One transfer on port 0 (inst) or 1 (data), response sampled mid-cycle
  task automatic bus_xfer(input logic port, input logic wr, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rd,
                          output logic resp_err);
    mcu_pkg::mas_send_type req;
    mcu_pkg::slv_send_type rsp;
    req.hreq   = 1'b1;
    req.hwrite = wr;
    req.haddr  = addr;
    req.hwdata = wdata;
    @(posedge clk);
    if (port) data_req <= req;
    else inst_req <= req;
    do begin
      @(negedge clk);
      rsp = port ? data_rsp : inst_rsp;
    end while (!rsp.hready);
    rd       = rsp.hrdata;
    resp_err = rsp.hresp;
    ss_snap  = {ss_3, ss_2, ss_1, ss_0};
    // Drop the request on the completing edge
    @(posedge clk);
    if (port) data_req <= '0;
    else inst_req <= '0;
  endtask

  task automatic write_word(input logic port, input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        resp_err;
    bus_xfer(port, 1'b1, addr, wdata, rd, resp_err);
    check_val("hresp", 32'h0, resp_err);
  endtask

  task automatic read_word(input logic port, input logic [31:0] addr, output logic [31:0] rd);
    logic resp_err;
    bus_xfer(port, 1'b0, addr, 32'h0, rd, resp_err);
    check_val("hresp", 32'h0, resp_err);
  endtask

  task automatic test_done(input string name);
    $display("test %-12s done, %0d errors", name, errors - test_err0);
    tests_run++;
    test_err0 = errors;
  endtask

  // --------------------
  // Tests
  // --------------------

  initial begin
    seed      = 89;
    errors    = 0;
    tests_run = 0;
    test_err0 = 0;
    rst_n     = 1'b0;
    inst_req  = '0;
    data_req  = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values before any request, then an unmapped SPI offset
    @(negedge clk);
    check_val("inst_rsp.hready", 32'h0, inst_rsp.hready);
    check_val("data_rsp.hready", 32'h0, data_rsp.hready);
    check_val("sclk", 32'h0, sclk);
    check_val("mosi_somi", 32'h0, mosi_somi);
    check_val("ss_3..ss_0", 32'hf, {ss_3, ss_2, ss_1, ss_0});
    bus_xfer(1'b1, 1'b0, peri_addr(8'h10), 32'h0, rdata, err);
    check_val("data_rsp.hresp", 32'h1, err);
    test_done("reset_perr");

    // Random words into distinct 64-word slices
    for (int i = 0; i < n_words; i++) begin
      addr_list[i] = 32'((i * 64 + ($random(seed) & 63)) * 4);
      word_list[i] = $random(seed);
      write_word(1'b1, addr_list[i], word_list[i]);
    end
    for (int i = 0; i < n_words; i++) begin
      read_word(1'b1, addr_list[i], rdata);
      check_val("hrdata", word_list[i], rdata);
    end
    test_done("mem_rw");

    // Both ports in the same cycle, twice so each wins a tie
    for (int r = 0; r < 2; r++) begin
      // Lone instruction read, so the data port is next in line
      if (r == 1) begin
        read_word(1'b0, addr_list[0], rdata);
        check_val("inst_rsp.hrdata", word_list[0], rdata);
      end
      fork
        bus_xfer(1'b0, 1'b0, addr_list[2 * r], 32'h0, rd_i, err_i);
        bus_xfer(1'b1, 1'b0, addr_list[2 * r + 1], 32'h0, rd_d, err_d);
      join
      check_val("inst_rsp.hrdata", word_list[2 * r], rd_i);
      check_val("inst_rsp.hresp", 32'h0, err_i);
      check_val("data_rsp.hrdata", word_list[2 * r + 1], rd_d);
      check_val("data_rsp.hresp", 32'h0, err_d);
    end
    test_done("arbitration");

    // Region 2 maps to nothing, memory at the same offset untouched
    bus_xfer(1'b1, 1'b1, {4'h2, addr_list[2][27:0]}, ~word_list[2], rdata, err);
    check_val("data_rsp.hresp", 32'h1, err);
    read_word(1'b1, addr_list[2], rdata);
    check_val("hrdata", word_list[2], rdata);
    test_done("decode_err");

    // Select enable plus slave 2, then one byte
    tx_byte = 8'($random(seed));
    write_word(1'b1, peri_addr(mcu_pkg::spi_ctrl_off),
               32'((1 << mcu_pkg::spi_ss_en_bit) | 2));
    write_word(1'b1, peri_addr(mcu_pkg::spi_txdata_off), {24'h0, tx_byte});
    polled_busy = 1'b0;
    ss_checked  = 1'b0;
    do begin
      read_word(1'b1, peri_addr(mcu_pkg::spi_status_off), rdata);
      if (rdata[mcu_pkg::spi_busy_bit]) begin
        // Busy on both sides of the earlier snapshot
        if (polled_busy) begin
          check_val("ss_3..ss_0", 32'hb, ss_prev);
          ss_checked = 1'b1;
        end
        polled_busy = 1'b1;
        ss_prev     = ss_snap;
      end
    end while (rdata[mcu_pkg::spi_busy_bit]);
    if (!ss_checked) begin
      $display("Error: STATUS never read busy twice, ss_2 was not sampled during the byte");
      errors++;
    end
    read_word(1'b1, peri_addr(mcu_pkg::spi_rxdata_off), rdata);
    check_val("rxdata", {24'h0, tx_byte}, rdata);
    test_done("spi_loopback");

    $display("tests %0d, check errors %0d, assertion failures %0d",
             tests_run, errors, DUT.u_chk.fail_cnt);
    if (errors == 0 && DUT.u_chk.fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== design/ahb_apb_bridge.sv ====
// System bus to peripheral bus bridge: setup and access phases per transfer
`timescale 1ns/1ps

module ahb_apb_bridge (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mcu_pkg::mas_send_type bus_req,
  input  logic                  sel,
  output mcu_pkg::slv_send_type bus_rsp,
  output mcu_pkg::apb_req_type  apb_req,
  input  mcu_pkg::apb_rsp_type  apb_rsp
);

  typedef enum logic [1:0] {
    idle,
    setup,
    access
  } state_t;

  state_t      state;
  logic        rsp_valid;  // Completing cycle on the system bus
  logic        rsp_err;
  logic        start;
  logic        done;
  // Captured transfer
  logic [7:0]  addr_q;
  logic        write_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;

  // New transfer only when the previous response is not on the bus
  assign start = (state == idle) && sel && !rsp_valid;
  assign done  = (state == access) && apb_rsp.pready;

  // --------------------
  // FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= idle;
      rsp_valid <= 1'b0;
      rsp_err   <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            state <= setup;
          end
        end
        setup: begin
          state <= access;
        end
        access: begin
          // Wait out pready
          if (apb_rsp.pready) begin
            state     <= idle;
            rsp_valid <= 1'b1;
            rsp_err   <= apb_rsp.pslverr;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Address low byte, direction, data
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q  <= bus_req.haddr[7:0];
      write_q <= bus_req.hwrite;
      wdata_q <= bus_req.hwdata;
    end
    if (done) begin
      rdata_q <= apb_rsp.prdata;
    end
  end

  // --------------------
  // Outputs
  // --------------------

  assign apb_req.psel    = (state != idle);
  assign apb_req.penable = (state == access);
  assign apb_req.pwrite  = write_q;
  assign apb_req.paddr   = addr_q;
  assign apb_req.pwdata  = wdata_q;

  assign bus_rsp.hrdata = rdata_q;
  assign bus_rsp.hready = rsp_valid;
  // pslverr maps onto hresp
  assign bus_rsp.hresp  = rsp_valid && rsp_err;

endmodule

// ==== design/bus_matrix.sv ====
// Bus matrix: round-robin arbiter for two masters, address decoder, response steering
`timescale 1ns/1ps

module bus_matrix (
  input  logic                  clk,
  input  logic                  rst_n,
  // Instruction master
  input  mcu_pkg::mas_send_type inst_req,
  output mcu_pkg::slv_send_type inst_rsp,
  // Data master
  input  mcu_pkg::mas_send_type data_req,
  output mcu_pkg::slv_send_type data_rsp,
  // Main memory slave
  output mcu_pkg::mas_send_type mem_req,
  output logic                  mem_sel,
  input  mcu_pkg::slv_send_type mem_rsp,
  // Peripheral bridge slave
  output mcu_pkg::mas_send_type peri_req,
  output logic                  peri_sel,
  input  mcu_pkg::slv_send_type peri_rsp
);

  // --------------------
  // State
  // --------------------

  logic busy;      // A granted transfer is in flight
  logic gnt_data;  // 0 = instruction port, 1 = data port
  logic rr_data;   // Port preferred on the next tie
  logic sel_mem;
  logic sel_peri;
  logic dec_err;   // Granted address hit no slave

  logic                  pick_data;
  logic [3:0]            pick_region;
  logic                  hit_mem;
  logic                  hit_peri;
  mcu_pkg::mas_send_type pick_req;
  mcu_pkg::mas_send_type gnt_req;
  mcu_pkg::slv_send_type gnt_rsp;

  // --------------------
  // Arbitration
  // --------------------

  // Tie goes to the round-robin pointer, otherwise to whoever asks
  always_comb begin
    if (inst_req.hreq && data_req.hreq) begin
      pick_data = rr_data;
    end else begin
      pick_data = data_req.hreq;
    end
  end

  assign pick_req    = pick_data ? data_req : inst_req;
  assign pick_region = pick_req.haddr[31:28];
  assign hit_mem     = (pick_region == mcu_pkg::mem_region);
  assign hit_peri    = (pick_region == mcu_pkg::peri_region);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      gnt_data <= 1'b0;
      rr_data  <= 1'b0;  // Instruction port first
      sel_mem  <= 1'b0;
      sel_peri <= 1'b0;
      dec_err  <= 1'b0;
    end else if (!busy) begin
      if (inst_req.hreq || data_req.hreq) begin
        busy     <= 1'b1;
        gnt_data <= pick_data;
        // Other port wins the next tie
        rr_data  <= !pick_data;
        // Decode once, at grant time
        sel_mem  <= hit_mem;
        sel_peri <= hit_peri;
        dec_err  <= !(hit_mem || hit_peri);
      end
    end else if (gnt_rsp.hready) begin
      // Transfer done, bus free next cycle
      busy     <= 1'b0;
      sel_mem  <= 1'b0;
      sel_peri <= 1'b0;
      dec_err  <= 1'b0;
    end
  end

  // --------------------
  // Routing
  // --------------------

  // Granted master holds its request stable, so no capture needed
  assign gnt_req  = gnt_data ? data_req : inst_req;
  assign mem_req  = gnt_req;
  assign peri_req = gnt_req;
  assign mem_sel  = sel_mem;
  assign peri_sel = sel_peri;

  // Response of the selected slave, or a local decode error
  always_comb begin
    gnt_rsp = '0;
    if (dec_err) begin
      gnt_rsp.hready = 1'b1;
      gnt_rsp.hresp  = 1'b1;
    end else if (sel_mem) begin
      gnt_rsp = mem_rsp;
    end else if (sel_peri) begin
      gnt_rsp = peri_rsp;
    end
  end

  // Only the granted master sees hready; the other one waits
  assign inst_rsp = (busy && !gnt_data) ? gnt_rsp : '0;
  assign data_rsp = (busy && gnt_data) ? gnt_rsp : '0;

endmodule

// ==== design/main_memory.sv ====
// Main memory: word-addressed RAM slave on the system bus, two-cycle access
`timescale 1ns/1ps

module main_memory #(
  parameter int mem_depth = 1024
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mcu_pkg::mas_send_type bus_req,
  input  logic                  sel,
  output mcu_pkg::slv_send_type bus_rsp
);

  // Word index width; depth taken as a power of two
  localparam int addr_w = (mem_depth > 1) ? $clog2(mem_depth) : 1;

  logic [31:0]       mem [mem_depth];
  logic [addr_w-1:0] idx;
  logic [31:0]       rdata;
  logic              ack;  // Completing cycle of the access

  // Byte address to word index, wraps at mem_depth
  assign idx = bus_req.haddr[addr_w+1:2];

  // --------------------
  // Handshake
  // --------------------

  // Ack one cycle after select first seen, then drop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= sel && !ack;
    end
  end

  // --------------------
  // Storage
  // --------------------

  always_ff @(posedge clk) begin
    // Read in the first selected cycle
    if (sel && !ack) begin
      rdata <= mem[idx];
    end
    // Write lands on the completing cycle
    if (sel && ack && bus_req.hwrite) begin
      mem[idx] <= bus_req.hwdata;
    end
  end

  assign bus_rsp.hrdata = rdata;
  assign bus_rsp.hready = ack;
  // Memory never errors
  assign bus_rsp.hresp  = 1'b0;

endmodule

// ==== design/mcu_pkg.sv ====
// MCU shared types: system bus and peripheral bus structs, address map, SPI registers
package mcu_pkg;

  // --------------------
  // System bus
  // --------------------

  // Master request, held stable until hready
  typedef struct packed {
    logic        hreq;    // Transfer wanted
    logic        hwrite;  // 1 = write, 0 = read
    logic [31:0] haddr;
    logic [31:0] hwdata;
  } mas_send_type;

  // Slave response, meaningful only in the hready cycle
  typedef struct packed {
    logic [31:0] hrdata;
    logic        hready;  // Transfer completes this cycle
    logic        hresp;   // Error
  } slv_send_type;

  // --------------------
  // Peripheral bus
  // --------------------

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;   // Register offset
    logic [31:0] pwdata;
  } apb_req_type;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_type;

  // Address map, compared against haddr[31:28]
  localparam logic [3:0] mem_region  = 4'h0;
  localparam logic [3:0] peri_region = 4'h4;

  // SPI register offsets
  localparam logic [7:0] spi_txdata_off = 8'h00;
  localparam logic [7:0] spi_rxdata_off = 8'h04;
  localparam logic [7:0] spi_status_off = 8'h08;
  localparam logic [7:0] spi_ctrl_off   = 8'h0C;

  // STATUS and CTRL fields
  localparam int spi_busy_bit  = 0;
  localparam int spi_ss_en_bit = 2;  // Slave-select index sits below, bits 1:0

endpackage

// ==== design/mcu_top.sv ====
// MCU top: two bus masters, bus matrix, main memory, peripheral bridge and SPI
`timescale 1ns/1ps

module mcu_top #(
  parameter int mem_depth   = 1024,
  parameter int spi_clk_div = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Master ports, standing in for the core
  input  mcu_pkg::mas_send_type inst_req,
  output mcu_pkg::slv_send_type inst_rsp,
  input  mcu_pkg::mas_send_type data_req,
  output mcu_pkg::slv_send_type data_rsp,
  // SPI pins
  output logic                  mosi_somi,
  output logic                  sclk,
  output logic                  ss_0,
  output logic                  ss_1,
  output logic                  ss_2,
  output logic                  ss_3,
  input  logic                  miso_simo
);

  // --------------------
  // Interconnect
  // --------------------

  mcu_pkg::mas_send_type mem_req;
  mcu_pkg::slv_send_type mem_rsp;
  logic                  mem_sel;
  mcu_pkg::mas_send_type peri_req;
  mcu_pkg::slv_send_type peri_rsp;
  logic                  peri_sel;
  mcu_pkg::apb_req_type  apb_req;
  mcu_pkg::apb_rsp_type  apb_rsp;

  bus_matrix u_matrix (
    .clk      (clk),
    .rst_n    (rst_n),
    .inst_req (inst_req),
    .inst_rsp (inst_rsp),
    .data_req (data_req),
    .data_rsp (data_rsp),
    .mem_req  (mem_req),
    .mem_sel  (mem_sel),
    .mem_rsp  (mem_rsp),
    .peri_req (peri_req),
    .peri_sel (peri_sel),
    .peri_rsp (peri_rsp)
  );

  main_memory #(
    .mem_depth (mem_depth)
  ) u_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (mem_req),
    .sel     (mem_sel),
    .bus_rsp (mem_rsp)
  );

  ahb_apb_bridge u_bridge (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (peri_req),
    .sel     (peri_sel),
    .bus_rsp (peri_rsp),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  // Only peripheral on the bridge
  spi_master #(
    .spi_clk_div (spi_clk_div)
  ) u_spi (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .mosi_somi (mosi_somi),
    .sclk      (sclk),
    .ss_0      (ss_0),
    .ss_1      (ss_1),
    .ss_2      (ss_2),
    .ss_3      (ss_3),
    .miso_simo (miso_simo)
  );

endmodule

// ==== design/spi_master.sv ====
// SPI master: peripheral-bus registers and 8-bit mode-0 shifter with four selects
`timescale 1ns/1ps

module spi_master #(
  parameter int spi_clk_div = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mcu_pkg::apb_req_type apb_req,
  output mcu_pkg::apb_rsp_type apb_rsp,
  output logic                 mosi_somi,
  output logic                 sclk,
  output logic                 ss_0,
  output logic                 ss_1,
  output logic                 ss_2,
  output logic                 ss_3,
  input  logic                 miso_simo
);

  localparam int div_w = (spi_clk_div > 1) ? $clog2(spi_clk_div) : 1;
  localparam logic [div_w-1:0] div_last = div_w'(spi_clk_div - 1);

  logic [2:0]       ctrl;      // Enable in bit 2, index in 1:0
  logic [7:0]       tx_data;
  logic [7:0]       tx_shift;
  logic [7:0]       rx_shift;
  logic [7:0]       rx_data;
  logic             busy;
  logic             sclk_q;
  logic             mosi_q;
  logic [div_w-1:0] div_cnt;
  logic [3:0]       edge_cnt;  // SCLK edges, 16 per byte
  logic             wr_en;
  logic             tx_wr;
  logic             half_end;  // Last cycle of a half period
  logic             last_edge;
  logic             in_map;
  logic [31:0]      rd_data;

  // --------------------
  // Register access
  // --------------------

  assign wr_en     = apb_req.psel && apb_req.penable && apb_req.pwrite;
  assign tx_wr     = wr_en && (apb_req.paddr == mcu_pkg::spi_txdata_off);
  assign half_end  = busy && (div_cnt == div_last);
  assign last_edge = (edge_cnt == 4'd15);

  always_comb begin
    rd_data = '0;
    in_map  = 1'b1;
    case (apb_req.paddr)
      mcu_pkg::spi_txdata_off: rd_data[7:0] = tx_data;
      mcu_pkg::spi_rxdata_off: rd_data[7:0] = rx_data;
      mcu_pkg::spi_status_off: rd_data[mcu_pkg::spi_busy_bit] = busy;
      mcu_pkg::spi_ctrl_off:   rd_data[2:0] = ctrl;
      default:                 in_map = 1'b0;
    endcase
  end

  // Zero-wait slave
  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = apb_req.psel && !in_map;

  // --------------------
  // Control and timing
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl     <= '0;
      busy     <= 1'b0;
      sclk_q   <= 1'b0;
      mosi_q   <= 1'b0;
      div_cnt  <= '0;
      edge_cnt <= '0;
    end else if (!busy) begin
      // CTRL frozen while a byte is on the wire
      if (wr_en && (apb_req.paddr == mcu_pkg::spi_ctrl_off)) begin
        ctrl <= apb_req.pwdata[2:0];
      end
      if (tx_wr) begin
        busy     <= 1'b1;
        mosi_q   <= apb_req.pwdata[7];  // MSB out before first rising edge
        div_cnt  <= '0;
        edge_cnt <= '0;
      end
    end else if (half_end) begin
      div_cnt  <= '0;
      sclk_q   <= !sclk_q;
      edge_cnt <= edge_cnt + 4'd1;
      // Falling edge: next bit out, or finish
      if (sclk_q) begin
        if (last_edge) begin
          busy   <= 1'b0;
          mosi_q <= 1'b0;
        end else begin
          mosi_q <= tx_shift[6];
        end
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // --------------------
  // Data path
  // --------------------

  always_ff @(posedge clk) begin
    if (!busy && tx_wr) begin
      tx_data  <= apb_req.pwdata[7:0];
      tx_shift <= apb_req.pwdata[7:0];
    end else if (half_end) begin
      if (!sclk_q) begin
        // Rising edge, sample MISO
        rx_shift <= {rx_shift[6:0], miso_simo};
      end else begin
        tx_shift <= {tx_shift[6:0], 1'b0};
        // Byte complete on the last falling edge
        if (last_edge) begin
          rx_data <= rx_shift;
        end
      end
    end
  end

  assign mosi_somi = mosi_q;
  assign sclk      = sclk_q;

  // Active-low selects, only while busy and enabled
  assign ss_0 = !(busy && ctrl[mcu_pkg::spi_ss_en_bit] && (ctrl[1:0] == 2'd0));
  assign ss_1 = !(busy && ctrl[mcu_pkg::spi_ss_en_bit] && (ctrl[1:0] == 2'd1));
  assign ss_2 = !(busy && ctrl[mcu_pkg::spi_ss_en_bit] && (ctrl[1:0] == 2'd2));
  assign ss_3 = !(busy && ctrl[mcu_pkg::spi_ss_en_bit] && (ctrl[1:0] == 2'd3));

endmodule

// ==== files.f ====
design/mcu_pkg.sv
design/bus_matrix.sv
design/main_memory.sv
design/ahb_apb_bridge.sv
design/spi_master.sv
design/mcu_top.sv
bench/mcu_assertions.sv
bench/mcu_tb.sv
